// File: rtl/wiener_pkg.sv
package wiener_pkg;

	localparam int PIX_W = 8;
	localparam int VAR_W = 16;   // Holds mean of squares for 8-bit pixels

	// Pixel on the input stream
	typedef struct packed {
		logic             sof;
		logic [PIX_W-1:0] data;
	} pix_in_t;

	// Filtered pixel with block/frame markers
	typedef struct packed {
		logic             last_of_block;
		logic             last_of_frame;
		logic [PIX_W-1:0] data;
	} pix_out_t;

	typedef struct packed {
		logic [PIX_W-1:0] mean;
		logic [VAR_W-1:0] variance;
	} block_stats_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Register file view handed to the datapath
	typedef struct packed {
		logic [15:0]      blocks_per_frame;
		logic [VAR_W-1:0] noise_var;
	} wiener_cfg_t;

	typedef enum logic [1:0] {
		IDLE         = 2'd0,
		READ_BLOCK   = 2'd1,
		WAIT_STATS   = 2'd2,
		EMPTY_BUFFER = 2'd3
	} ctrl_state_e;

	typedef enum logic [3:0] {
		REG_BLOCKS = 4'h0,
		REG_NOISE  = 4'h4,
		REG_STATUS = 4'h8
	} reg_addr_e;

endpackage

// File: rtl/wiener_apb_regs.sv
module wiener_apb_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  wiener_pkg::apb_req_t   apb_req,
	output logic [31:0]            prdata,
	input  logic                   busy,
	input  logic                   frame_done,
	output wiener_pkg::wiener_cfg_t cfg
);
	import wiener_pkg::*;

	logic [15:0]      blocks_q;
	logic [VAR_W-1:0] noise_q;
	logic [15:0]      frames_done_q;
	logic             wr_en;
	logic             rd_en;
	reg_addr_e        addr;

	assign addr  = reg_addr_e'(apb_req.paddr);
	// No wait states, access phase does the work
	assign wr_en = apb_req.psel & apb_req.penable & apb_req.pwrite;
	assign rd_en = apb_req.psel & ~apb_req.pwrite;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blocks_q <= 16'd1;
			noise_q  <= '0;
		end else if (wr_en) begin
			case (addr)
				REG_BLOCKS: blocks_q <= apb_req.pwdata[15:0];
				REG_NOISE:  noise_q  <= apb_req.pwdata[VAR_W-1:0];
				default:    ;   // Status is read only
			endcase
		end
	end

	// Frame counter wraps silently
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frames_done_q <= '0;
		end else if (frame_done) begin
			frames_done_q <= frames_done_q + 16'd1;
		end
	end

	always_comb begin
		prdata = '0;
		if (rd_en) begin
			case (addr)
				REG_BLOCKS: prdata = {16'd0, blocks_q};
				REG_NOISE:  prdata = {{(32 - VAR_W){1'b0}}, noise_q};
				REG_STATUS: prdata = {frames_done_q, 15'd0, busy};
				default:    prdata = '0;
			endcase
		end
	end

	assign cfg.blocks_per_frame = blocks_q;
	assign cfg.noise_var        = noise_q;

endmodule

// File: rtl/wiener_block_ctrl.sv
module wiener_block_ctrl #(
	parameter int BLOCK_SAMPLES = 16
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    pix_valid,
	input  logic                    pix_sof,
	output logic                    pix_ready,
	input  logic                    out_ready,
	output logic                    out_valid,
	input  wiener_pkg::wiener_cfg_t cfg,
	output logic                    shift_en,
	output logic                    accumulate,
	output logic                    finish,
	output logic                    last_of_block,
	output logic                    last_of_frame,
	output logic                    busy,
	output logic                    frame_done
);
	import wiener_pkg::*;

	localparam int CNT_W = $clog2(BLOCK_SAMPLES);
	localparam logic [CNT_W-1:0] LAST_SAMPLE = CNT_W'(BLOCK_SAMPLES - 1);

	ctrl_state_e      state;
	ctrl_state_e      next_state;
	logic [CNT_W-1:0] sample_cnt;
	logic [15:0]      block_cnt;
	logic [15:0]      last_block;
	logic             in_xfer;
	logic             out_xfer;
	logic             take;
	logic             last_sample;
	logic             end_of_frame;

	// Zero blocks behaves like one block
	assign last_block = (cfg.blocks_per_frame == 16'd0) ? 16'd0
	                                                    : cfg.blocks_per_frame - 16'd1;

	assign in_xfer      = pix_valid & pix_ready;
	assign out_xfer     = out_valid & out_ready;
	assign last_sample  = (sample_cnt == LAST_SAMPLE);
	assign end_of_frame = (block_cnt == last_block);

	// Pixels that enter the block buffer; non-sof pixels in IDLE are dropped
	assign take = in_xfer & ((state == READ_BLOCK) | ((state == IDLE) & pix_sof));

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (in_xfer && pix_sof) begin
					next_state = READ_BLOCK;
				end
			end
			READ_BLOCK: begin
				if (in_xfer && last_sample) begin
					next_state = WAIT_STATS;
				end
			end
			WAIT_STATS: begin
				next_state = EMPTY_BUFFER;   // Stats land in the gain stage here
			end
			EMPTY_BUFFER: begin
				if (out_xfer && last_sample) begin
					next_state = end_of_frame ? IDLE : READ_BLOCK;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			pix_ready <= 1'b0;
		end else begin
			state     <= next_state;
			pix_ready <= (next_state == IDLE) || (next_state == READ_BLOCK);
		end
	end

	// Sample count follows every shift, wraps at block end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt <= '0;
		end else if (shift_en) begin
			sample_cnt <= sample_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			block_cnt <= '0;
		end else if (state == IDLE) begin
			block_cnt <= '0;
		end else if (out_xfer && last_sample) begin
			block_cnt <= block_cnt + 16'd1;
		end
	end

	assign accumulate = take;
	assign shift_en   = take | out_xfer;
	assign finish     = take & (state == READ_BLOCK) & last_sample;

	assign out_valid     = (state == EMPTY_BUFFER);
	assign last_of_block = out_valid & last_sample;
	assign last_of_frame = last_of_block & end_of_frame;
	assign frame_done    = out_xfer & last_of_frame;   // Single pulse per frame
	assign busy          = (state != IDLE);

endmodule

// File: rtl/sample_delay_line.sv
module sample_delay_line #(
	parameter int BLOCK_SAMPLES = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         shift_en,
	input  logic [wiener_pkg::PIX_W-1:0] din,
	output logic [wiener_pkg::PIX_W-1:0] dout
);
	import wiener_pkg::*;

	logic [PIX_W-1:0] taps [BLOCK_SAMPLES];

	// Tap 0 is newest, last tap is the oldest sample of the block
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BLOCK_SAMPLES; i++) begin
				taps[i] <= '0;
			end
		end else if (shift_en) begin
			taps[0] <= din;
			for (int i = 1; i < BLOCK_SAMPLES; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	assign dout = taps[BLOCK_SAMPLES-1];

endmodule

// File: rtl/block_stats.sv
module block_stats #(
	parameter int BLOCK_SAMPLES = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         accumulate,
	input  logic                         finish,
	input  logic [wiener_pkg::PIX_W-1:0] din,
	output wiener_pkg::block_stats_t     stats,
	output logic                         stats_valid
);
	import wiener_pkg::*;

	localparam int SHIFT = $clog2(BLOCK_SAMPLES);
	localparam int SUM_W = PIX_W + SHIFT;
	localparam int SQ_W  = 2 * PIX_W + SHIFT;

	logic [SUM_W-1:0]   sum_q;
	logic [SUM_W-1:0]   sum_next;
	logic [SQ_W-1:0]    sq_q;
	logic [SQ_W-1:0]    sq_next;
	logic [2*PIX_W-1:0] din_sq;
	logic [PIX_W-1:0]   mean;
	logic [VAR_W-1:0]   mean_of_sq;
	logic [VAR_W-1:0]   mean_pow;
	logic [VAR_W-1:0]   variance;

	assign din_sq   = din * din;
	// Running totals including the current sample, so finish sees the last pixel
	assign sum_next = sum_q + SUM_W'(din);
	assign sq_next  = sq_q + SQ_W'(din_sq);

	assign mean       = PIX_W'(sum_next >> SHIFT);
	assign mean_of_sq = VAR_W'(sq_next >> SHIFT);
	assign mean_pow   = VAR_W'(mean) * VAR_W'(mean);

	// Truncation can make the difference go negative in principle
	assign variance = (mean_of_sq > mean_pow) ? mean_of_sq - mean_pow : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_q       <= '0;
			sq_q        <= '0;
			stats_valid <= 1'b0;
		end else begin
			stats_valid <= finish;   // One cycle after the last sample
			if (finish) begin
				sum_q <= '0;
				sq_q  <= '0;
			end else if (accumulate) begin
				sum_q <= sum_next;
				sq_q  <= sq_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (finish) begin
			stats.mean     <= mean;
			stats.variance <= variance;
		end
	end

endmodule

// File: rtl/wiener_gain.sv
module wiener_gain (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         stats_valid,
	input  wiener_pkg::block_stats_t     stats,
	input  logic [wiener_pkg::VAR_W-1:0] noise_var,
	input  logic [wiener_pkg::PIX_W-1:0] din,
	output logic [wiener_pkg::PIX_W-1:0] dout
);
	import wiener_pkg::*;

	localparam int PROD_W = PIX_W + VAR_W + 2;
	localparam logic signed [PROD_W-1:0] PIX_MAX = (1 << PIX_W) - 1;

	logic [PIX_W-1:0]         mean_q;
	logic [VAR_W-1:0]         var_q;
	logic [VAR_W-1:0]         sig_q;      // Signal variance, noise removed
	logic [VAR_W-1:0]         divisor;
	logic signed [PIX_W:0]    dev;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] quot;
	logic signed [PROD_W-1:0] result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mean_q <= '0;
			var_q  <= '0;
			sig_q  <= '0;
		end else if (stats_valid) begin
			mean_q <= stats.mean;
			var_q  <= stats.variance;
			sig_q  <= (stats.variance > noise_var) ? stats.variance - noise_var : '0;
		end
	end

	assign dev     = $signed({1'b0, din}) - $signed({1'b0, mean_q});
	assign prod    = dev * $signed({1'b0, sig_q});
	assign divisor = (var_q == '0) ? VAR_W'(1) : var_q;   // Result unused when zero
	assign quot    = prod / $signed({1'b0, divisor});     // Truncates toward zero
	assign result  = $signed({1'b0, mean_q}) + quot;

	always_comb begin
		if (var_q == '0) begin
			dout = mean_q;   // Flat block
		end else if (result < 0) begin
			dout = '0;
		end else if (result > PIX_MAX) begin
			dout = '1;
		end else begin
			dout = result[PIX_W-1:0];
		end
	end

endmodule

// File: rtl/wiener_denoise_top.sv
module wiener_denoise_top #(
	parameter int BLOCK_SAMPLES = 16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  wiener_pkg::apb_req_t apb_req,
	output logic [31:0]          prdata,
	output logic                 pready,
	input  wiener_pkg::pix_in_t  pix_in,
	input  logic                 pix_valid,
	output logic                 pix_ready,
	output wiener_pkg::pix_out_t pix_out,
	output logic                 out_valid,
	input  logic                 out_ready
);
	import wiener_pkg::*;

	wiener_cfg_t      cfg;
	block_stats_t     stats;
	logic             stats_valid;
	logic             busy;
	logic             frame_done;
	logic             shift_en;
	logic             accumulate;
	logic             finish;
	logic [PIX_W-1:0] oldest_pix;

	assign pready = 1'b1;   // Registers always answer at once

	wiener_apb_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.apb_req    (apb_req),
		.prdata     (prdata),
		.busy       (busy),
		.frame_done (frame_done),
		.cfg        (cfg)
	);

	wiener_block_ctrl #(.BLOCK_SAMPLES(BLOCK_SAMPLES)) u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.pix_valid     (pix_valid),
		.pix_sof       (pix_in.sof),
		.pix_ready     (pix_ready),
		.out_ready     (out_ready),
		.out_valid     (out_valid),
		.cfg           (cfg),
		.shift_en      (shift_en),
		.accumulate    (accumulate),
		.finish        (finish),
		.last_of_block (pix_out.last_of_block),
		.last_of_frame (pix_out.last_of_frame),
		.busy          (busy),
		.frame_done    (frame_done)
	);

	sample_delay_line #(.BLOCK_SAMPLES(BLOCK_SAMPLES)) u_delay (
		.clk      (clk),
		.rst_n    (rst_n),
		.shift_en (shift_en),
		.din      (pix_in.data),
		.dout     (oldest_pix)
	);

	block_stats #(.BLOCK_SAMPLES(BLOCK_SAMPLES)) u_stats (
		.clk         (clk),
		.rst_n       (rst_n),
		.accumulate  (accumulate),
		.finish      (finish),
		.din         (pix_in.data),
		.stats       (stats),
		.stats_valid (stats_valid)
	);

	wiener_gain u_gain (
		.clk         (clk),
		.rst_n       (rst_n),
		.stats_valid (stats_valid),
		.stats       (stats),
		.noise_var   (cfg.noise_var),
		.din         (oldest_pix),
		.dout        (pix_out.data)
	);

endmodule

// File: testbench/tb_wiener_denoise.sv
module tb_wiener_denoise;
	import wiener_pkg::*;

	localparam int BLK = 16;
	localparam int TIMEOUT = 2000;   // Cycles per wait
	localparam logic [31:0] SEED = 32'h92d7;

	typedef logic [BLK-1:0][PIX_W-1:0] block_t;

	logic        clk;
	logic        rst_n;
	apb_req_t    apb_req;
	logic [31:0] prdata;
	logic        pready;
	pix_in_t     pix_in;
	logic        pix_valid;
	logic        pix_ready;
	pix_out_t    pix_out;
	logic        out_valid;
	logic        out_ready;

	pix_out_t    exp_q[$];       // Expected outputs in order
	string       test_name;
	int          out_count;
	int          noise_cfg;
	bit          random_ready;
	logic [31:0] pix_rng;
	logic [31:0] rdy_rng;
	logic [31:0] rd_data;

	wiener_denoise_top #(.BLOCK_SAMPLES(BLK)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_values(input string label, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Fail %s %s: expected %0h, actual %0h", test_name, label,
				expected, actual));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic block_t random_block();
		block_t b;
		for (int i = 0; i < BLK; i++) begin
			pix_rng = xorshift32(pix_rng);
			b[i] = pix_rng[PIX_W-1:0];
		end
		return b;
	endfunction

	// Block mean and variance, then the Wiener gain per pixel
	function automatic block_t wiener_ref(input block_t pix, input int noise);
		block_t res;
		int     sum;
		int     sum_sq;
		int     mean;
		int     var_b;
		int     sig;
		int     val;
		sum = 0;
		sum_sq = 0;
		for (int i = 0; i < BLK; i++) begin
			sum    += int'(pix[i]);
			sum_sq += int'(pix[i]) * int'(pix[i]);
		end
		mean  = sum >> $clog2(BLK);
		var_b = (sum_sq >> $clog2(BLK)) - mean * mean;
		if (var_b < 0) begin
			var_b = 0;
		end
		sig = (var_b > noise) ? var_b - noise : 0;
		for (int i = 0; i < BLK; i++) begin
			if (var_b == 0) begin
				val = mean;
			end else begin
				val = mean + ((int'(pix[i]) - mean) * sig) / var_b;   // Truncates toward zero
			end
			if (val < 0) begin
				val = 0;
			end else if (val > 255) begin
				val = 255;
			end
			res[i] = PIX_W'(val);
		end
		return res;
	endfunction

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	// Access phase ends once pready is seen high
	task automatic apb_access(input logic [3:0] addr, input logic write,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		@(negedge clk);
		while (!pready) begin
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("Timeout waiting for pready on the APB bus");
			end
			@(negedge clk);
		end
		rdata = prdata;
		@(posedge clk);
		#2;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(addr, 1'b1, data, unused);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		apb_access(addr, 1'b0, 32'd0, data);
	endtask

	task automatic send_pixel(input logic [PIX_W-1:0] data, input logic sof);
		int waited;
		waited = 0;
		pix_in.sof  = sof;
		pix_in.data = data;
		pix_valid   = 1'b1;
		@(negedge clk);
		while (!pix_ready) begin
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("Timeout waiting for pix_ready to accept a pixel");
			end
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		pix_valid = 1'b0;
	endtask

	// Expected values are queued only once the whole block is in
	task automatic send_block(input block_t pix, input bit sof, input bit frame_end,
			input bit identity);
		block_t   exp_pix;
		pix_out_t entry;
		for (int i = 0; i < BLK; i++) begin
			send_pixel(pix[i], sof && (i == 0));
		end
		exp_pix = identity ? pix : wiener_ref(pix, noise_cfg);
		for (int i = 0; i < BLK; i++) begin
			entry.data          = exp_pix[i];
			entry.last_of_block = (i == BLK - 1);
			entry.last_of_frame = frame_end && (i == BLK - 1);
			exp_q.push_back(entry);
		end
	endtask

	task automatic send_frame(input int nblocks, input bit identity);
		for (int b = 0; b < nblocks; b++) begin
			send_block(random_block(), b == 0, b == nblocks - 1, identity);
		end
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT) begin
				abort_run("Timeout waiting for the DUT to deliver all block outputs");
			end
		end
		@(posedge clk);
		#2;
	endtask

	// Random out_ready only while back-pressure is enabled
	initial begin
		forever begin
			@(posedge clk);
			#2;
			if (random_ready) begin
				rdy_rng = xorshift32(rdy_rng);
				out_ready = rdy_rng[3];
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	// Compare process, sampled mid-cycle where all signals are settled
	initial begin
		pix_out_t exp;
		forever begin
			@(negedge clk);
			if (rst_n) begin
				if (exp_q.size() != 0 && pix_ready) begin
					abort_run("pix_ready was high while block outputs were still pending");
				end
				if (out_valid && out_ready) begin
					if (exp_q.size() == 0) begin
						abort_run("DUT produced an output when none was expected");
					end
					exp = exp_q.pop_front();
					compare_values($sformatf("output %0d", out_count), exp, pix_out);
					out_count++;
				end
			end
		end
	end

	initial begin
		int start_count;
		rst_n        = 1'b0;
		apb_req      = '0;
		pix_in       = '0;
		pix_valid    = 1'b0;
		out_ready    = 1'b1;
		random_ready = 1'b0;
		pix_rng      = SEED;
		rdy_rng      = xorshift32(SEED);
		out_count    = 0;
		noise_cfg    = 0;
		test_name    = "reset";
		apply_reset();

		test_name = "registers";
		apb_read(REG_STATUS, rd_data);
		compare_values("status busy", 32'd0, {31'd0, rd_data[0]});
		apb_read(REG_BLOCKS, rd_data);
		compare_values("blocks reset value", 32'd1, rd_data);
		apb_write(REG_BLOCKS, 32'd5);
		apb_read(REG_BLOCKS, rd_data);
		compare_values("blocks readback", 32'd5, rd_data);
		apb_write(REG_NOISE, 32'h0000_beef);
		apb_read(REG_NOISE, rd_data);
		compare_values("noise readback", 32'h0000_beef, rd_data);
		apb_read(4'hC, rd_data);
		compare_values("unmapped read", 32'd0, rd_data);

		test_name = "flat blocks";
		apb_write(REG_BLOCKS, 32'd1);
		for (int n = 0; n < 2; n++) begin
			noise_cfg = n * 300;
			apb_write(REG_NOISE, noise_cfg);
			for (int v = 0; v < 3; v++) begin
				send_block({BLK{PIX_W'((v * 255) / 2)}}, 1'b1, 1'b1, 1'b1);
				wait_drained();
			end
		end

		// Unit gain, so outputs equal inputs
		test_name = "zero noise";
		noise_cfg = 0;
		apb_write(REG_NOISE, 32'd0);
		apb_write(REG_BLOCKS, 32'd2);
		send_frame(2, 1'b1);
		wait_drained();

		test_name = "random frame";
		noise_cfg = 200;
		apb_write(REG_NOISE, 32'd200);
		apb_write(REG_BLOCKS, 32'd3);
		start_count = out_count;
		send_frame(3, 1'b0);
		wait_drained();
		compare_values("output count", 32'd48, out_count - start_count);

		test_name = "back-pressure";
		random_ready = 1'b1;
		start_count  = out_count;
		send_frame(3, 1'b0);
		wait_drained();
		random_ready = 1'b0;
		compare_values("output count", 32'd48, out_count - start_count);

		// Fresh reset so the frame counter starts at zero
		test_name = "frame count";
		apply_reset();
		noise_cfg = 0;
		for (int i = 0; i < 5; i++) begin
			send_pixel(PIX_W'(i * 37 + 11), 1'b0);
		end
		repeat (30) begin
			@(negedge clk);
			if (out_valid) begin
				abort_run("Pixels without start of frame produced an output");
			end
		end
		@(posedge clk);
		#2;
		send_frame(1, 1'b0);
		wait_drained();
		send_frame(1, 1'b0);
		wait_drained();
		apb_read(REG_STATUS, rd_data);
		compare_values("frames done", 32'd2, {16'd0, rd_data[31:16]});
		compare_values("status busy", 32'd0, {31'd0, rd_data[0]});

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: flist.f
rtl/wiener_pkg.sv
rtl/wiener_apb_regs.sv
rtl/wiener_block_ctrl.sv
rtl/sample_delay_line.sv
rtl/block_stats.sv
rtl/wiener_gain.sv
rtl/wiener_denoise_top.sv
testbench/tb_wiener_denoise.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Wiener denoiser testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_wiener_denoise \
	-o tb_wiener_denoise --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_wiener_denoise > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
